/* compile.f */
logic/extmem_cfg_pkg.sv
logic/extmem_beat_pkg.sv
logic/beat_if.sv
logic/beat_sequencer.sv
logic/lane_datapath.sv
logic/ahb_extmem_bridge.sv
test/extmem_model.sv
test/tb_ahb_extmem_bridge.sv

/* test/tb_ahb_extmem_bridge.sv */
//----------------------------------------------------------
// Testbench for the AHB to external memory bridge
// Directed and random AHB transfers checked against a
// shadow byte memory, with beat counting and HREADYOUT rules
//----------------------------------------------------------
`timescale 1ns/1ps

module tb_ahb_extmem_bridge;
  import extmem_cfg_pkg::*;

  localparam int          ADDR_W       = ADDR_W_DEFAULT;
  localparam logic [31:0] SEED_INIT    = 32'h652c2d72;
  localparam int          N_DIRECTED   = 32;     // Transfers in tests 2 to 4
  localparam int          N_RANDOM     = 200;
  localparam int          LIMIT_CYCLES = (N_DIRECTED + N_RANDOM) * 4 * 6 + 100;

  logic              HCLK;
  logic              HRESETn;
  logic              hsel;
  logic [ADDR_W-1:0] haddr;
  logic [1:0]        htrans;
  xfer_size_t        hsize;
  logic              hwrite;
  ahb_data_t         hwdata;
  logic              hready;
  logic              hreadyout;
  ahb_data_t         hrdata;
  mem_width_e        mem_width;
  logic [ADDR_W-1:0] mem_addr;
  mem_data_t         mem_dataout;
  logic              rd_req;
  logic              wr_req;
  logic [1:0]        byte_mask;
  mem_data_t         mem_datain;
  logic              mem_done;

  integer            seed;
  int                errors;
  int                test_base;                // Errors before current test
  int                n_xfers;
  int                n_reads;
  logic [1:0]        first_mask;               // Mask on first beat
  logic [7:0]        shadow [0:(2**ADDR_W)-1];
  logic [ADDR_W-1:0] rd_addr_q [$];            // Finished reads to compare
  xfer_size_t        rd_size_q [$];
  ahb_data_t         rd_data_q [$];
  event              read_done;

  assign hready = hreadyout;                   // Single slave bus

  ahb_extmem_bridge #(.ADDR_W(ADDR_W)) i_ahb_extmem_bridge (
    .HCLK, .HRESETn,
    .i_hsel(hsel), .i_haddr(haddr), .i_htrans(htrans), .i_hsize(hsize),
    .i_hwrite(hwrite), .i_hwdata(hwdata), .i_hready(hready),
    .o_hreadyout(hreadyout), .o_hrdata(hrdata), .i_mem_width(mem_width),
    .o_addr(mem_addr), .o_dataout(mem_dataout), .o_rd_req(rd_req),
    .o_wr_req(wr_req), .o_byte_mask(byte_mask), .i_datain(mem_datain),
    .i_done(mem_done)
  );

  extmem_model #(.ADDR_W(ADDR_W), .SEED(SEED_INIT)) i_extmem_model (
    .HCLK, .HRESETn, .i_mem_width(mem_width), .i_addr(mem_addr),
    .i_dataout(mem_dataout), .i_rd_req(rd_req), .i_wr_req(wr_req),
    .i_byte_mask(byte_mask), .o_datain(mem_datain), .o_done(mem_done)
  );

  initial
  begin
    HCLK = 1'b0;
    forever #5 HCLK = ~HCLK;                   // 100 MHz
  end

  //----------------------------------------------------------
  // Reference model
  //----------------------------------------------------------
  function automatic logic [7:0] fill_byte(input int a);
    return a[7:0] ^ a[15:8] ^ 8'h3c;           // Differs across the address
  endfunction

  function automatic ahb_data_t lane_mask(input logic [ADDR_W-1:0] addr,
                                          input xfer_size_t size);
    ahb_data_t mask;
    int        k;
    mask = '0;
    for (k = 0; k < 4; k++)
      if (k >= addr[1:0] && k < addr[1:0] + (1 << size))
        mask[8*k +: 8] = 8'hff;               // Lanes the size covers
    return mask;
  endfunction

  function automatic ahb_data_t expect_read(input logic [ADDR_W-1:0] addr,
                                            input xfer_size_t size);
    ahb_data_t mask;
    ahb_data_t word;
    int        k;
    mask = lane_mask(addr, size);
    word = '0;
    for (k = 0; k < 4; k++)
      if (mask[8*k])
        word[8*k +: 8] = shadow[{addr[ADDR_W-1:2], 2'b00} + k];
    return word;
  endfunction

  function automatic void update_shadow(input logic [ADDR_W-1:0] addr,
                                        input xfer_size_t size, input ahb_data_t data);
    ahb_data_t mask;
    int        k;
    mask = lane_mask(addr, size);
    for (k = 0; k < 4; k++)
      if (mask[8*k])
        shadow[{addr[ADDR_W-1:2], 2'b00} + k] = data[8*k +: 8];
  endfunction

  function automatic int expected_beats(input mem_width_e width, input xfer_size_t size);
    if (width == MEM_8)
      return 1 << size;                        // One byte per beat
    else
      return (size == 2'b10) ? 2 : 1;          // Only a word needs two halves
  endfunction

  //----------------------------------------------------------
  // Reporting and stimulus
  //----------------------------------------------------------
  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    errors++;
  endtask

  task automatic print_test_result(input string name);
    @(posedge HCLK);                           // Let pending compares run
    $display("%s: %s, %0d errors", name, (errors == test_base) ? "pass" : "fail",
             errors - test_base);
    test_base = errors;
  endtask

  task automatic check_idle_outputs;
    if (rd_req !== 1'b0)
      report_mismatch("o_rd_req", rd_req, 0);
    if (wr_req !== 1'b0)
      report_mismatch("o_wr_req", wr_req, 0);
    if (byte_mask !== 2'b00)
      report_mismatch("o_byte_mask", byte_mask, 0);
    if (hreadyout !== 1'b1)
      report_mismatch("o_hreadyout", hreadyout, 1);
    if (mem_addr !== '0)
      report_mismatch("o_addr", mem_addr, 0);
    if (mem_dataout !== '0)
      report_mismatch("o_dataout", mem_dataout, 0);
  endtask

  task automatic run_transfer(input mem_width_e width, input logic write,
                              input logic [ADDR_W-1:0] addr, input xfer_size_t size,
                              input ahb_data_t data);
    int   beats;
    logic fin;
    beats = 0;
    fin   = 1'b0;
    @(posedge HCLK);                           // Address phase
    mem_width <= width;
    hsel      <= 1'b1;
    haddr     <= addr;
    htrans    <= 2'b10;                        // NONSEQ
    hsize     <= size;
    hwrite    <= write;
    @(posedge HCLK);                           // Bus idle, HREADY took it
    hsel      <= 1'b0;
    htrans    <= 2'b00;
    if (write)
      hwdata <= data;                          // Data phase write word
    while (!fin)
    begin
      @(negedge HCLK);                         // Outputs settled mid cycle
      if (mem_done)
      begin
        if (beats == 0)
          first_mask = byte_mask;
        beats++;
      end
      fin = hreadyout;
    end
    n_xfers++;
    if (mem_done !== 1'b1)
      report_mismatch("i_done with o_hreadyout", mem_done, 1);
    if (beats != expected_beats(width, size))
      report_mismatch("i_done pulses", beats, expected_beats(width, size));
    if (write)
      update_shadow(addr, size, data);
    else
    begin
      rd_addr_q.push_back(addr);
      rd_size_q.push_back(size);
      rd_data_q.push_back(hrdata);             // Valid in the last done cycle
      -> read_done;
    end
  endtask

  // Compares every finished read with the shadow memory
  initial
  begin : compare_reads
    logic [ADDR_W-1:0] a;
    xfer_size_t        s;
    ahb_data_t         got;
    forever
    begin
      @(read_done);
      while (rd_data_q.size() > 0)
      begin
        a   = rd_addr_q.pop_front();
        s   = rd_size_q.pop_front();
        got = rd_data_q.pop_front() & lane_mask(a, s);
        n_reads++;
        if (got !== expect_read(a, s))
          report_mismatch("o_hrdata", got, expect_read(a, s));
      end
    end
  end

  initial
  begin : watchdog
    repeat (LIMIT_CYCLES) @(posedge HCLK);
    $display("Run did not finish within %0d cycles, bridge stopped answering",
             LIMIT_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  //----------------------------------------------------------
  // Test sequence
  //----------------------------------------------------------
  initial
  begin : main_sequence
    int                i;
    int                sz;
    int                k;
    int                n;
    logic [ADDR_W-1:0] a;
    ahb_data_t         r;
    seed       = SEED_INIT;
    errors     = 0;
    test_base  = 0;
    n_xfers    = 0;
    n_reads    = 0;
    first_mask = 2'b00;
    HRESETn    = 1'b0;
    hsel       = 1'b0;
    haddr      = '0;
    htrans     = 2'b00;
    hsize      = 2'b00;
    hwrite     = 1'b0;
    hwdata     = '0;
    mem_width  = MEM_8;
    for (i = 0; i < 2**ADDR_W; i++)
    begin
      shadow[i]                = fill_byte(i);
      i_extmem_model.mem[i]    = fill_byte(i);  // Same start contents
    end

    // Test 1, outputs in and after reset
    repeat (3) @(posedge HCLK);
    @(negedge HCLK);
    check_idle_outputs();
    @(posedge HCLK);
    HRESETn <= 1'b1;                           // Released after 4 cycles
    @(negedge HCLK);
    check_idle_outputs();
    print_test_result("test 1 reset values");

    // Test 2, byte wide memory round trips
    for (sz = 0; sz < 3; sz++)
      for (k = 0; k < 4; k += (1 << sz))
      begin
        a = 16'h0140 + k;
        r = $random(seed);
        run_transfer(MEM_8, 1'b1, a, sz[1:0], r);
        run_transfer(MEM_8, 1'b0, a, sz[1:0], '0);
      end
    print_test_result("test 2 8-bit memory");

    // Test 3, halfword wide memory, byte mask per byte write
    for (sz = 0; sz < 3; sz++)
      for (k = 0; k < 4; k += (1 << sz))
      begin
        a = 16'h0280 + k;
        r = $random(seed);
        run_transfer(MEM_16, 1'b1, a, sz[1:0], r);
        if (sz == 0 && first_mask !== (a[0] ? 2'b10 : 2'b01))
          report_mismatch("o_byte_mask", first_mask, a[0] ? 2'b10 : 2'b01);
        run_transfer(MEM_16, 1'b0, a, sz[1:0], '0);
      end
    print_test_result("test 3 16-bit memory");

    // Test 4, stall across multi beat transfers
    run_transfer(MEM_8, 1'b1, 16'h0300, 2'b10, 32'h0badcafe);
    run_transfer(MEM_8, 1'b0, 16'h0300, 2'b10, '0);
    run_transfer(MEM_16, 1'b0, 16'h0300, 2'b10, '0);
    run_transfer(MEM_8, 1'b0, 16'h0302, 2'b01, '0);
    print_test_result("test 4 ready stall");

    // Test 5, random mix of sizes, widths and directions
    for (n = 0; n < N_RANDOM; n++)
    begin
      r  = $random(seed);
      sz = (r[1:0] == 2'b11) ? 2 : r[1:0];
      a  = r[31:16] & 16'h0c1f;                // Four 32 byte windows
      if (sz == 1)
        a[0] = 1'b0;
      if (sz == 2)
        a[1:0] = 2'b00;
      run_transfer(r[2] ? MEM_16 : MEM_8, r[3], a, sz[1:0], $random(seed));
    end
    print_test_result("test 5 random transfers");

    $display("transfers %0d, reads compared %0d, errors %0d", n_xfers, n_reads, errors);
    if (errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

/* test/extmem_model.sv */
//----------------------------------------------------------
// External memory model for the bridge testbench
// Byte array that closes each beat after 2 to 5 cycles
//----------------------------------------------------------
`timescale 1ns/1ps

module extmem_model #(
  parameter int          ADDR_W = 16,
  parameter logic [31:0] SEED   = 32'h652c2d72
) (
  input  logic              HCLK,
  input  logic              HRESETn,
  input  logic              i_mem_width,  // High for 16-bit memory
  input  logic [ADDR_W-1:0] i_addr,       // Beat byte address
  input  logic [15:0]       i_dataout,    // Bridge write lanes
  input  logic              i_rd_req,
  input  logic              i_wr_req,
  input  logic [1:0]        i_byte_mask,  // Lane enables
  output logic [15:0]       o_datain,     // Read lanes toward bridge
  output logic              o_done        // One cycle beat end
);

  logic [7:0]        mem [0:(2**ADDR_W)-1];   // Filled by the testbench
  integer            seed = SEED;
  integer            lat;                     // Edges until done rises
  logic              busy;                    // Beat in flight
  logic              beat_wr;                 // Direction of that beat
  logic [2:0]        wait_cnt;
  logic [ADDR_W-1:0] addr_even;
  logic [ADDR_W-1:0] addr_odd;

  assign addr_even = {i_addr[ADDR_W-1:1], 1'b0};  // Halfword pair
  assign addr_odd  = {i_addr[ADDR_W-1:1], 1'b1};

  always @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      o_done   <= 1'b0;
      o_datain <= '0;
      busy     <= 1'b0;
      beat_wr  <= 1'b0;
      wait_cnt <= '0;
    end
    else
    begin
      if (o_done)
      begin
        o_done <= 1'b0;
        busy   <= 1'b0;
        if (beat_wr && !i_mem_width)
          mem[i_addr] <= i_dataout[7:0];     // Byte wide, lower lane only
        else if (beat_wr)
        begin
          if (i_byte_mask[0])
            mem[addr_even] <= i_dataout[7:0];
          if (i_byte_mask[1])
            mem[addr_odd] <= i_dataout[15:8];
        end
      end
      if ((i_rd_req || i_wr_req) && (!busy || o_done))
      begin
        lat      = ($random(seed) & 3) + 1;  // Done lands in cycle 2 to 5
        busy     <= 1'b1;
        beat_wr  <= i_wr_req;                 // Request may drop with done
        wait_cnt <= lat[2:0];
      end
      else if (busy && !o_done)
      begin
        if (wait_cnt == 3'd1)
        begin
          o_done   <= 1'b1;
          o_datain <= i_mem_width ? {mem[addr_odd], mem[addr_even]}
                                  : {8'h00, mem[i_addr]};
        end
        wait_cnt <= wait_cnt - 3'd1;
      end
    end
  end

endmodule

/* logic/ahb_extmem_bridge.sv */
//----------------------------------------------------------
// AHB-Lite to narrow external memory bridge
// Sequencer and lane data path joined by a beat bundle
//----------------------------------------------------------
`timescale 1ns/1ps

module ahb_extmem_bridge #(
  parameter int ADDR_W = extmem_cfg_pkg::ADDR_W_DEFAULT
) (
  input  logic                       HCLK,
  input  logic                       HRESETn,
  // AHB-Lite slave side
  input  logic                       i_hsel,
  input  logic [ADDR_W-1:0]          i_haddr,
  input  logic [1:0]                 i_htrans,
  input  extmem_cfg_pkg::xfer_size_t i_hsize,
  input  logic                       i_hwrite,
  input  extmem_cfg_pkg::ahb_data_t  i_hwdata,
  input  logic                       i_hready,
  output logic                       o_hreadyout,
  output extmem_cfg_pkg::ahb_data_t  o_hrdata,
  // Configuration
  input  extmem_cfg_pkg::mem_width_e i_mem_width,  // Held static
  // External memory side
  output logic [ADDR_W-1:0]          o_addr,
  output extmem_cfg_pkg::mem_data_t  o_dataout,
  output logic                       o_rd_req,
  output logic                       o_wr_req,
  output logic [1:0]                 o_byte_mask,
  input  extmem_cfg_pkg::mem_data_t  i_datain,
  input  logic                       i_done
);

  beat_if u_beat_if ();               // Sequencer to data path

  beat_sequencer #(.ADDR_W(ADDR_W)) u_beat_sequencer (
    .HCLK, .HRESETn, .i_hsel, .i_haddr, .i_htrans, .i_hsize,
    .i_hwrite, .i_hready, .i_mem_width, .i_done,
    .o_addr, .o_rd_req, .o_wr_req, .o_byte_mask, .o_hreadyout,
    .bus (u_beat_if.seq)
  );

  lane_datapath u_lane_datapath (
    .HCLK, .HRESETn, .i_hwdata, .i_datain, .i_done, .i_mem_width,
    .o_dataout, .o_hrdata,
    .bus (u_beat_if.dp)
  );

endmodule

/* logic/lane_datapath.sv */
//----------------------------------------------------------
// Lane data path for the external memory bridge
// Routes write bytes onto memory lanes and gathers read
// bytes into the AHB read word
//----------------------------------------------------------
`timescale 1ns/1ps

module lane_datapath (
  input  logic                       HCLK,
  input  logic                       HRESETn,
  input  extmem_cfg_pkg::ahb_data_t  i_hwdata,     // AHB write data
  input  extmem_cfg_pkg::mem_data_t  i_datain,     // Memory read data
  input  logic                       i_done,       // Beat complete pulse
  input  extmem_cfg_pkg::mem_width_e i_mem_width,  // Static memory width
  output extmem_cfg_pkg::mem_data_t  o_dataout,    // Memory write data
  output extmem_cfg_pkg::ahb_data_t  o_hrdata,     // AHB read data
  beat_if.dp                         bus           // From sequencer
);
  import extmem_cfg_pkg::*;
  import extmem_beat_pkg::*;

  mem_data_t  lanes;                  // Routed write bytes
  logic       rd_capture;             // Read beat completing
  logic [7:0] rd_buf0;                // AHB byte 0
  logic [7:0] rd_buf1;                // AHB byte 1
  logic [7:0] rd_buf2;                // AHB byte 2

  //----------------------------------------------------------
  // Write routing
  //----------------------------------------------------------
  assign lanes[7:0]  = i_hwdata[8*bus.lower_sel +: 8];
  assign lanes[15:8] = i_hwdata[8*bus.upper_sel +: 8];

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      o_dataout <= '0;
    else if (bus.active)
      o_dataout <= lanes;             // HWDATA valid only in data phase
  end

  //----------------------------------------------------------
  // Read buffering
  //----------------------------------------------------------
  assign rd_capture = bus.active & ~bus.write & i_done;

  always_ff @(posedge HCLK)
  begin
    if (rd_capture)
    begin
      if (bus.lower_sel == 2'b00)
        rd_buf0 <= i_datain[7:0];     // First beat of an aligned access
      if (bus.state == ST_W16_HI)
        rd_buf1 <= i_datain[15:8];    // Lower half of word on 16-bit
      else if (bus.state == ST_W8_B2)
        rd_buf1 <= i_datain[7:0];
      if ((bus.state == ST_H8_B1) || (bus.state == ST_W8_B3))
        rd_buf2 <= i_datain[7:0];     // Byte 2, or byte 0 of a low half
    end
  end

  // Last beat comes straight from the memory
  always_comb
  begin
    if (i_mem_width == MEM_8)
    begin
      case (bus.size)
        2'b00:   o_hrdata = {4{i_datain[7:0]}};
        2'b01:   o_hrdata = {i_datain[7:0], rd_buf2, i_datain[7:0], rd_buf0};
        default: o_hrdata = {i_datain[7:0], rd_buf2, rd_buf1, rd_buf0};
      endcase
    end
    else
    begin
      if (bus.size[1])
        o_hrdata = {i_datain, rd_buf1, rd_buf0};  // Word in two halves
      else
        o_hrdata = {2{i_datain}};     // Byte or half on both halves
    end
  end

  // Memory completes beats only for requests the bridge issued
  a_done_active: assert property (@(posedge HCLK) disable iff (!HRESETn)
    i_done |-> bus.active);

endmodule

/* logic/beat_sequencer.sv */
//----------------------------------------------------------
// Beat sequencer for the AHB to external memory bridge
// Splits each AHB transfer into byte or halfword beats,
// drives memory address, requests and mask, and holds
// HREADYOUT low until the last beat completes
//----------------------------------------------------------
`timescale 1ns/1ps

module beat_sequencer #(
  parameter int ADDR_W = 16
) (
  input  logic                       HCLK,
  input  logic                       HRESETn,
  input  logic                       i_hsel,       // Slave select
  input  logic [ADDR_W-1:0]          i_haddr,      // Address phase address
  input  logic [1:0]                 i_htrans,     // Transfer type
  input  extmem_cfg_pkg::xfer_size_t i_hsize,      // Transfer size
  input  logic                       i_hwrite,     // Direction
  input  logic                       i_hready,     // Bus ready
  input  extmem_cfg_pkg::mem_width_e i_mem_width,  // Static memory width
  input  logic                       i_done,       // Beat complete pulse
  output logic [ADDR_W-1:0]          o_addr,       // Memory byte address
  output logic                       o_rd_req,     // Read request
  output logic                       o_wr_req,     // Write request
  output logic [1:0]                 o_byte_mask,  // Memory lane enables
  output logic                       o_hreadyout,  // Bus stall control
  beat_if.seq                        bus           // Toward data path
);
  import extmem_cfg_pkg::*;
  import extmem_beat_pkg::*;

  //----------------------------------------------------------
  // Data phase capture
  //----------------------------------------------------------
  logic trans_valid;                  // Accepted address phase
  logic reg_active;
  logic reg_write;
  xfer_size_t reg_size;

  // Beat state and its next value
  beat_state_e state_q, state_d;
  logic [1:0] addr_low_q, addr_low_d;                 // Byte within word
  logic [ADDR_W-3:0] addr_high_q, addr_high_d;        // Word address
  lane_sel_t lower_sel_q, lower_sel_d;
  lane_sel_t upper_sel_q, upper_sel_d;
  logic [1:0] byte_mask_q, byte_mask_d;
  logic rd_req_q, wr_req_q;           // Last cycle requests
  logic rd_req, wr_req;

  assign trans_valid = i_hsel & i_hready & i_htrans[1];  // NONSEQ or SEQ

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      reg_active <= 1'b0;
      reg_write  <= 1'b0;
      reg_size   <= 2'b00;
    end
    else if (i_hready)
    begin
      reg_active <= trans_valid;      // Bus only advances with HREADY
      reg_write  <= i_hwrite;
      reg_size   <= i_hsize;
    end
  end

  //----------------------------------------------------------
  // Beat state machine
  //----------------------------------------------------------
  always_comb
  begin
    state_d     = state_q;            // Hold everything between beats
    addr_low_d  = addr_low_q;
    addr_high_d = addr_high_q;
    lower_sel_d = lower_sel_q;
    upper_sel_d = upper_sel_q;
    byte_mask_d = byte_mask_q;
    rd_req      = ~reg_write;         // Mid transfer requests stay up
    wr_req      = reg_write;
    case (state_q)
      ST_FIRST:
      begin
        if (trans_valid)
        begin
          addr_low_d  = i_haddr[1:0];
          addr_high_d = i_haddr[ADDR_W-1:2];
          rd_req      = ~i_hwrite;    // Request rises with address phase
          wr_req      = i_hwrite;
          if (i_mem_width == MEM_8)
          begin
            lower_sel_d = i_haddr[1:0];  // Addressed byte first
            upper_sel_d = 2'b01;         // Upper lane idle
            byte_mask_d = 2'b01;
            case (i_hsize)
              2'b00:   state_d = ST_FIRST;   // Single beat
              2'b01:   state_d = ST_H8_B1;   // Two beats
              default: state_d = ST_W8_B1;   // Four beats
            endcase
          end
          else
          begin
            lower_sel_d = {i_haddr[1], 1'b0};  // Even byte of half
            upper_sel_d = {i_haddr[1], 1'b1};  // Odd byte of half
            if (i_hsize == 2'b00)
              byte_mask_d = {i_haddr[0], ~i_haddr[0]};  // One lane only
            else
              byte_mask_d = 2'b11;
            if (i_hsize[1])
              state_d = ST_W16_HI;    // Word needs two halves
          end
        end
        else
        begin
          rd_req = rd_req_q & ~i_done;  // Last beat closes the request
          wr_req = wr_req_q & ~i_done;
        end
      end
      ST_W16_HI:
      begin
        if (i_done)
        begin
          state_d     = ST_FIRST;
          addr_low_d  = 2'b10;        // Upper halfword
          lower_sel_d = 2'b10;
          upper_sel_d = 2'b11;
        end
      end
      ST_W8_B1:
      begin
        if (i_done)
        begin
          state_d     = ST_W8_B2;
          addr_low_d  = 2'b01;
          lower_sel_d = 2'b01;
        end
      end
      ST_W8_B2:
      begin
        if (i_done)
        begin
          state_d     = ST_W8_B3;
          addr_low_d  = 2'b10;
          lower_sel_d = 2'b10;
        end
      end
      ST_W8_B3:
      begin
        if (i_done)
        begin
          state_d     = ST_FIRST;
          addr_low_d  = 2'b11;
          lower_sel_d = 2'b11;
        end
      end
      ST_H8_B1:
      begin
        if (i_done)
        begin
          state_d     = ST_FIRST;
          addr_low_d  = {addr_low_q[1], 1'b1};  // Odd byte of the half
          lower_sel_d = {addr_low_q[1], 1'b1};
        end
      end
      default: state_d = ST_FIRST;   // Recover from unused codes
    endcase
  end

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      state_q     <= ST_FIRST;
      addr_low_q  <= 2'b00;
      addr_high_q <= '0;
      lower_sel_q <= 2'b00;
      upper_sel_q <= 2'b00;
      byte_mask_q <= 2'b00;
      rd_req_q    <= 1'b0;
      wr_req_q    <= 1'b0;
    end
    else
    begin
      state_q     <= state_d;
      addr_low_q  <= addr_low_d;
      addr_high_q <= addr_high_d;
      lower_sel_q <= lower_sel_d;
      upper_sel_q <= upper_sel_d;
      byte_mask_q <= byte_mask_d;
      rd_req_q    <= rd_req;
      wr_req_q    <= wr_req;
    end
  end

  //----------------------------------------------------------
  // Outputs
  //----------------------------------------------------------
  assign o_addr      = {addr_high_q, addr_low_q};
  assign o_byte_mask = byte_mask_q;   // Stable across the whole beat
  assign o_rd_req    = rd_req;
  assign o_wr_req    = wr_req;
  assign o_hreadyout = ~reg_active | ((state_q == ST_FIRST) & i_done);

  assign bus.state     = state_q;
  assign bus.lower_sel = lower_sel_q;
  assign bus.upper_sel = upper_sel_q;
  assign bus.active    = reg_active;
  assign bus.write     = reg_write;
  assign bus.size      = reg_size;

  // A request drops only in the cycle that closes a beat
  a_req_drop_done: assert property (@(posedge HCLK) disable iff (!HRESETn)
    ($fell(o_rd_req) || $fell(o_wr_req)) |-> i_done);

  // Bus stays stalled while beats remain
  a_ready_mid_xfer: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (state_q != ST_FIRST) |-> !o_hreadyout);

endmodule

/* logic/beat_if.sv */
//----------------------------------------------------------
// Beat control bundle
// Sequencer state and lane selects toward the data path
//----------------------------------------------------------
`timescale 1ns/1ps

interface beat_if;
  import extmem_cfg_pkg::*;
  import extmem_beat_pkg::*;

  beat_state_e state;                 // Current sequencer state
  lane_sel_t   lower_sel;             // AHB byte on memory bits 7:0
  lane_sel_t   upper_sel;             // AHB byte on memory bits 15:8
  logic        active;                // Data phase in progress
  logic        write;                 // Data phase direction
  xfer_size_t  size;                  // Data phase size

  //----------------------------------------------------------
  // Sequencer drives, data path listens
  //----------------------------------------------------------
  modport seq (
    output state, lower_sel, upper_sel, active, write, size
  );

  modport dp (
    input  state, lower_sel, upper_sel, active, write, size
  );

endinterface

/* logic/extmem_beat_pkg.sv */
//----------------------------------------------------------
// Beat sequencing types shared by sequencer and data path
//----------------------------------------------------------

package extmem_beat_pkg;

  // State names give the beat still owed after the current one.
  // The last beat of every transfer runs in ST_FIRST
  typedef enum logic [2:0] {
    ST_FIRST  = 3'b000,               // Idle or final beat
    ST_W8_B1  = 3'b001,               // Word on 8-bit, byte 1 next
    ST_W8_B2  = 3'b011,               // Word on 8-bit, byte 2 next
    ST_W8_B3  = 3'b010,               // Word on 8-bit, byte 3 next
    ST_W16_HI = 3'b100,               // Word on 16-bit, upper half next
    ST_H8_B1  = 3'b101                // Halfword on 8-bit, odd byte next
  } beat_state_e;

  //----------------------------------------------------------
  // Byte index within the AHB word
  //----------------------------------------------------------
  typedef logic [1:0] lane_sel_t;

endpackage

/* logic/extmem_cfg_pkg.sv */
//----------------------------------------------------------
// External memory bridge configuration types
// Address width default, memory width and bus data words
//----------------------------------------------------------

package extmem_cfg_pkg;

  //----------------------------------------------------------
  // Address space
  //----------------------------------------------------------
  parameter int ADDR_W_DEFAULT = 16;  // 64 KB external memory

  //----------------------------------------------------------
  // Memory data path width, static strap
  //----------------------------------------------------------
  typedef enum logic {
    MEM_8  = 1'b0,                    // Byte wide memory
    MEM_16 = 1'b1                     // Halfword wide memory
  } mem_width_e;

  //----------------------------------------------------------
  // Bus and memory words
  //----------------------------------------------------------
  typedef logic [1:0]  xfer_size_t;   // Low two bits of HSIZE
  typedef logic [15:0] mem_data_t;    // One memory word
  typedef logic [31:0] ahb_data_t;    // One AHB data word

endpackage
